// File: common/cache_pkg.sv
package cache_pkg;

  // line geometry
  localparam int LINE_BYTES = 64;
  localparam int NUM_LINES  = 16;

  // core address split, tag | index | byte offset
  localparam int OFFSET_W   = 6;
  localparam int INDEX_W    = 4;
  localparam int TAG_W      = 22;

  // eight 64-bit words per line
  localparam int WORD_SEL_W = 3;

  // byte address from the core
  typedef logic [TAG_W+INDEX_W+OFFSET_W-1:0] addr_t;

  // one core data word
  typedef logic [63:0] word_t;

  // whole cache line, moved as one unit to and from memory
  typedef logic [LINE_BYTES*8-1:0] line_t;

  // stored tag per line
  typedef logic [TAG_W-1:0] tag_t;

  // line index into the arrays
  typedef logic [INDEX_W-1:0] index_t;

endpackage

// File: common/bus_pkg.sv
package bus_pkg;

  // memory bus address is wider than the core address
  localparam int BUS_ADDR_W = 64;

  // size code for doubleword beats
  localparam logic [1:0] BUS_SIZE_D = 2'd3;

  // block count minus one, 7 means eight beats per line
  localparam logic [7:0] BUS_BLKS_LINE = 8'd7;

  // transfer direction
  typedef enum logic {
    BUS_READ  = 1'b0,
    BUS_WRITE = 1'b1
  } bus_op_t;

  // full width bus address
  typedef logic [BUS_ADDR_W-1:0] bus_addr_t;

endpackage

// File: cache/cache_store.sv
`timescale 1ns/1ps

module cache_store (
  input  logic                             clk,
  input  logic                             rst,
  // registered lookup
  input  logic                             i_lookup_en,
  input  cache_pkg::index_t                i_lookup_index,
  output cache_pkg::tag_t                  o_hit_tag,
  output logic                             o_hit_valid,
  output logic                             o_hit_dirty,
  output cache_pkg::line_t                 o_line,
  // single word write, marks the line dirty
  input  logic                             i_word_we,
  input  cache_pkg::index_t                i_word_index,
  input  logic [cache_pkg::WORD_SEL_W-1:0] i_word_sel,
  input  cache_pkg::word_t                 i_word_data,
  // whole line fill from memory
  input  logic                             i_fill_we,
  input  cache_pkg::index_t                i_fill_index,
  input  cache_pkg::tag_t                  i_fill_tag,
  input  cache_pkg::line_t                 i_fill_line
);
  import cache_pkg::*;

  // storage arrays
  line_t data_mem [NUM_LINES];
  tag_t  tag_mem  [NUM_LINES];
  logic  valid_mem [NUM_LINES];
  logic  dirty_mem [NUM_LINES];

  // state bits, the only part cleared on reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_LINES; i++) begin
        valid_mem[i] <= 1'b0;
        dirty_mem[i] <= 1'b0;
      end
      o_hit_valid <= 1'b0;
      o_hit_dirty <= 1'b0;
    end else begin
      if (i_lookup_en) begin
        o_hit_valid <= valid_mem[i_lookup_index];
        o_hit_dirty <= dirty_mem[i_lookup_index];
      end
      // fill brings in a clean copy
      if (i_fill_we) begin
        valid_mem[i_fill_index] <= 1'b1;
        dirty_mem[i_fill_index] <= 1'b0;
      end
      if (i_word_we) begin
        dirty_mem[i_word_index] <= 1'b1;
      end
    end
  end

  // data and tag arrays plus their read registers
  always_ff @(posedge clk) begin
    if (i_lookup_en) begin
      o_hit_tag <= tag_mem[i_lookup_index];
      o_line    <= data_mem[i_lookup_index];
    end
    if (i_fill_we) begin
      tag_mem[i_fill_index]  <= i_fill_tag;
      data_mem[i_fill_index] <= i_fill_line;
    end
    // word lane within the line
    if (i_word_we) begin
      data_mem[i_word_index][i_word_sel*$bits(word_t) +: $bits(word_t)] <= i_word_data;
    end
  end

endmodule

// File: cache/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl (
  input  logic                             clk,
  input  logic                             rst,
  // core request and response
  input  logic                             i_cpu_valid,
  input  logic                             i_cpu_we,
  input  cache_pkg::addr_t                 i_cpu_addr,
  input  cache_pkg::word_t                 i_cpu_wdata,
  output logic                             o_cpu_ready,
  output logic                             o_cpu_resp_valid,
  output cache_pkg::word_t                 o_cpu_rdata,
  // store lookup
  output logic                             o_lookup_en,
  output cache_pkg::index_t                o_lookup_index,
  input  cache_pkg::tag_t                  i_hit_tag,
  input  logic                             i_hit_valid,
  input  logic                             i_hit_dirty,
  input  cache_pkg::line_t                 i_line,
  // store writes
  output logic                             o_word_we,
  output cache_pkg::index_t                o_word_index,
  output logic [cache_pkg::WORD_SEL_W-1:0] o_word_sel,
  output cache_pkg::word_t                 o_word_data,
  output logic                             o_fill_we,
  output cache_pkg::index_t                o_fill_index,
  output cache_pkg::tag_t                  o_fill_tag,
  output cache_pkg::line_t                 o_fill_line,
  // line requests to the bridge
  output logic                             o_line_req,
  output bus_pkg::bus_op_t                 o_line_op,
  output cache_pkg::addr_t                 o_line_addr,
  output cache_pkg::line_t                 o_line_wdata,
  input  logic                             i_line_ack,
  input  cache_pkg::line_t                 i_line_rdata
);
  import cache_pkg::*;
  import bus_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_WRITEBACK,
    ST_REFILL,
    ST_FINISH
  } state_t;

  state_t                 state;
  // latched core request
  addr_t                  req_addr;
  logic                   req_we;
  word_t                  req_wdata;
  tag_t                   req_tag;
  index_t                 req_index;
  logic [WORD_SEL_W-1:0]  req_sel;
  logic                   accept;
  logic                   hit;
  // request taken, response not yet given
  logic                   resp_pending;

  // one word lane out of a line
  function automatic word_t pick_word(line_t line, logic [WORD_SEL_W-1:0] sel);
    return line[sel*$bits(word_t) +: $bits(word_t)];
  endfunction

  assign req_tag   = req_addr[$bits(addr_t)-1 -: TAG_W];
  assign req_index = req_addr[OFFSET_W +: INDEX_W];
  assign req_sel   = req_addr[OFFSET_W-1 -: WORD_SEL_W];

  assign o_cpu_ready = (state == ST_IDLE);
  assign accept      = i_cpu_valid && o_cpu_ready;

  // lookup starts straight from the core address
  assign o_lookup_en    = accept;
  assign o_lookup_index = i_cpu_addr[OFFSET_W +: INDEX_W];

  // store result is one cycle old, compare against latched tag
  assign hit = i_hit_valid && (i_hit_tag == req_tag);

  // store word goes in on a hit, or after the fill on a miss
  assign o_word_we    = req_we && ((state == ST_LOOKUP && hit) || state == ST_FINISH);
  assign o_word_index = req_index;
  assign o_word_sel   = req_sel;
  assign o_word_data  = req_wdata;

  // refill lands in the cycle of the ack
  assign o_fill_we    = (state == ST_REFILL) && i_line_ack;
  assign o_fill_index = req_index;
  assign o_fill_tag   = req_tag;
  assign o_fill_line  = i_line_rdata;

  // request held for the whole writeback or refill state
  assign o_line_req   = (state == ST_WRITEBACK) || (state == ST_REFILL);
  assign o_line_op    = (state == ST_WRITEBACK) ? BUS_WRITE : BUS_READ;
  // victim address rebuilt from stored tag
  assign o_line_addr  = (state == ST_WRITEBACK) ? {i_hit_tag, req_index, {OFFSET_W{1'b0}}}
                                                : {req_tag, req_index, {OFFSET_W{1'b0}}};
  // lookup line stays put until the next acceptance
  assign o_line_wdata = i_line;

  always_ff @(posedge clk) begin
    if (rst) begin
      state            <= ST_IDLE;
      req_we           <= 1'b0;
      o_cpu_resp_valid <= 1'b0;
    end else begin
      o_cpu_resp_valid <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (accept) begin
            req_addr  <= i_cpu_addr;
            req_we    <= i_cpu_we;
            req_wdata <= i_cpu_wdata;
            state     <= ST_LOOKUP;
          end
        end
        ST_LOOKUP: begin
          if (hit) begin
            o_cpu_resp_valid <= 1'b1;
            o_cpu_rdata      <= req_we ? req_wdata : pick_word(i_line, req_sel);
            state            <= ST_IDLE;
          end else if (i_hit_valid && i_hit_dirty) begin
            state <= ST_WRITEBACK;
          end else begin
            state <= ST_REFILL;
          end
        end
        ST_WRITEBACK: begin
          if (i_line_ack) begin
            state <= ST_REFILL;
          end
        end
        ST_REFILL: begin
          // grab the word now, the line is only valid this cycle
          if (i_line_ack) begin
            o_cpu_rdata <= req_we ? req_wdata : pick_word(i_line_rdata, req_sel);
            state       <= ST_FINISH;
          end
        end
        ST_FINISH: begin
          o_cpu_resp_valid <= 1'b1;
          state            <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      resp_pending <= 1'b0;
    end else if (accept) begin
      resp_pending <= 1'b1;
    end else if (o_cpu_resp_valid) begin
      resp_pending <= 1'b0;
    end
  end

  // at most one core request in flight
  a_single_request: assert property (@(posedge clk) disable iff (rst)
    accept |-> (!resp_pending || o_cpu_resp_valid));

  // bridge handshake, request and its payload held until acked
  a_line_req_held: assert property (@(posedge clk) disable iff (rst)
    (o_line_req && !i_line_ack) |=>
      (o_line_req && $stable(o_line_op) && $stable(o_line_addr) && $stable(o_line_wdata)));

endmodule

// File: cache/cache_line_bridge.sv
`timescale 1ns/1ps

module cache_line_bridge (
  input  logic               clk,
  input  logic               rst,
  // held line request from the controller
  input  logic               i_line_req,
  input  bus_pkg::bus_op_t   i_line_op,
  input  cache_pkg::addr_t   i_line_addr,
  input  cache_pkg::line_t   i_line_wdata,
  output logic               o_line_ack,
  output cache_pkg::line_t   o_line_rdata,
  // wide memory bus
  output logic               o_bus_valid,
  output bus_pkg::bus_op_t   o_bus_op,
  output bus_pkg::bus_addr_t o_bus_addr,
  output cache_pkg::line_t   o_bus_wdata,
  output logic [1:0]         o_bus_size,
  output logic [7:0]         o_bus_blks,
  input  logic               i_bus_ready,
  input  cache_pkg::line_t   i_bus_rdata
);
  import cache_pkg::*;
  import bus_pkg::*;

  typedef enum logic [1:0] {
    BR_IDLE,
    BR_BUSY,
    BR_ACK
  } br_state_t;

  br_state_t state;
  logic      bus_hs;

  // one burst finished
  assign bus_hs = o_bus_valid && i_bus_ready;

  assign o_bus_valid = (state == BR_BUSY);
  assign o_line_ack  = (state == BR_ACK);

  // fixed burst shape, eight doubleword beats per line
  assign o_bus_size = BUS_SIZE_D;
  assign o_bus_blks = BUS_BLKS_LINE;

  // controller holds these until ack, so no local copy
  assign o_bus_op    = i_line_op;
  assign o_bus_wdata = i_line_wdata;
  // zero extend, force line alignment
  assign o_bus_addr  = {{(BUS_ADDR_W-$bits(addr_t)){1'b0}},
                        i_line_addr[$bits(addr_t)-1:OFFSET_W], {OFFSET_W{1'b0}}};

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= BR_IDLE;
    end else begin
      case (state)
        // new transfer only from idle, ack cycle sits in between
        BR_IDLE:  if (i_line_req) state <= BR_BUSY;
        BR_BUSY:  if (bus_hs) state <= BR_ACK;
        BR_ACK:   state <= BR_IDLE;
        default:  state <= BR_IDLE;
      endcase
    end
  end

  // read line captured at the handshake
  always_ff @(posedge clk) begin
    if (bus_hs) begin
      o_line_rdata <= i_bus_rdata;
    end
  end

  // back-pressure only stretches the transfer
  a_bus_stall_stable: assert property (@(posedge clk) disable iff (rst)
    (o_bus_valid && !i_bus_ready) |=>
      (o_bus_valid && $stable(o_bus_op) && $stable(o_bus_addr) && $stable(o_bus_wdata)));

  // bus address is the requested line, no offset bits dropped on the way
  a_bus_addr_aligned: assert property (@(posedge clk) disable iff (rst)
    o_bus_valid |-> (i_line_addr[OFFSET_W-1:0] == '0));

endmodule

// File: rtl/cache_top.sv
`timescale 1ns/1ps

module cache_top (
  input  logic               clk,
  input  logic               rst,
  // core port
  input  logic               i_cpu_valid,
  input  logic               i_cpu_we,
  input  cache_pkg::addr_t   i_cpu_addr,
  input  cache_pkg::word_t   i_cpu_wdata,
  output logic               o_cpu_ready,
  output logic               o_cpu_resp_valid,
  output cache_pkg::word_t   o_cpu_rdata,
  // memory bus
  output logic               o_bus_valid,
  output bus_pkg::bus_op_t   o_bus_op,
  output bus_pkg::bus_addr_t o_bus_addr,
  output cache_pkg::line_t   o_bus_wdata,
  output logic [1:0]         o_bus_size,
  output logic [7:0]         o_bus_blks,
  input  logic               i_bus_ready,
  input  cache_pkg::line_t   i_bus_rdata
);
  import cache_pkg::*;
  import bus_pkg::*;

  // controller to store
  logic                  lookup_en;
  index_t                lookup_index;
  tag_t                  hit_tag;
  logic                  hit_valid;
  logic                  hit_dirty;
  line_t                 store_line;
  logic                  word_we;
  index_t                word_index;
  logic [WORD_SEL_W-1:0] word_sel;
  word_t                 word_data;
  logic                  fill_we;
  index_t                fill_index;
  tag_t                  fill_tag;
  line_t                 fill_line;
  // controller to bridge
  logic                  line_req;
  bus_op_t               line_op;
  addr_t                 line_addr;
  line_t                 line_wdata;
  logic                  line_ack;
  line_t                 line_rdata;

  cache_store store_i (
    .clk, .rst,
    .i_lookup_en(lookup_en), .i_lookup_index(lookup_index),
    .o_hit_tag(hit_tag), .o_hit_valid(hit_valid), .o_hit_dirty(hit_dirty),
    .o_line(store_line),
    .i_word_we(word_we), .i_word_index(word_index), .i_word_sel(word_sel),
    .i_word_data(word_data),
    .i_fill_we(fill_we), .i_fill_index(fill_index), .i_fill_tag(fill_tag),
    .i_fill_line(fill_line)
  );

  cache_ctrl ctrl_i (
    .clk, .rst,
    .i_cpu_valid, .i_cpu_we, .i_cpu_addr, .i_cpu_wdata,
    .o_cpu_ready, .o_cpu_resp_valid, .o_cpu_rdata,
    .o_lookup_en(lookup_en), .o_lookup_index(lookup_index),
    .i_hit_tag(hit_tag), .i_hit_valid(hit_valid), .i_hit_dirty(hit_dirty),
    .i_line(store_line),
    .o_word_we(word_we), .o_word_index(word_index), .o_word_sel(word_sel),
    .o_word_data(word_data),
    .o_fill_we(fill_we), .o_fill_index(fill_index), .o_fill_tag(fill_tag),
    .o_fill_line(fill_line),
    .o_line_req(line_req), .o_line_op(line_op), .o_line_addr(line_addr),
    .o_line_wdata(line_wdata), .i_line_ack(line_ack), .i_line_rdata(line_rdata)
  );

  cache_line_bridge bridge_i (
    .clk, .rst,
    .i_line_req(line_req), .i_line_op(line_op), .i_line_addr(line_addr),
    .i_line_wdata(line_wdata), .o_line_ack(line_ack), .o_line_rdata(line_rdata),
    .o_bus_valid, .o_bus_op, .o_bus_addr, .o_bus_wdata, .o_bus_size, .o_bus_blks,
    .i_bus_ready, .i_bus_rdata
  );

endmodule

// File: test/bus_mem_model.sv
`timescale 1ns/1ps

module bus_mem_model (
  input  logic               clk,
  input  logic               rst,
  // burst request from the DUT
  input  logic               i_valid,
  input  bus_pkg::bus_op_t   i_op,
  input  bus_pkg::bus_addr_t i_addr,
  input  cache_pkg::line_t   i_wdata,
  input  logic [1:0]         i_size,
  input  logic [7:0]         i_blks,
  output logic               o_ready,
  output cache_pkg::line_t   o_rdata,
  // transfer counters and error flag for the testbench
  output int                 o_reads,
  output int                 o_writes,
  output logic               o_error
);
  import cache_pkg::*;
  import bus_pkg::*;

  // written lines only, the rest reads as the fill pattern
  line_t     mem [bus_addr_t];
  logic      in_xfer;
  int        wait_left;
  // burst as first seen, for the stall check
  bus_op_t   held_op;
  bus_addr_t held_addr;
  line_t     held_wdata;

  function automatic line_t fetch_line(bus_addr_t base);
    line_t     l;
    bus_addr_t a;
    if (mem.exists(base)) begin
      return mem[base];
    end
    // pattern per 8-byte word, built from the full address
    for (int i = 0; i < LINE_BYTES / 8; i++) begin
      a = base + bus_addr_t'(8 * i);
      l[i*64 +: 64] = {a[63:32] ^ a[31:0] ^ 32'h5a5a_c3c3, a[31:0] ^ 32'h0f0f_1234};
    end
    return l;
  endfunction

  task automatic flag_error(input string msg);
    $display("bus model at %0t: %s", $time, msg);
    o_error = 1'b1;
  endtask

  initial begin
    void'($urandom(5111));
    o_ready   = 1'b0;
    o_rdata   = '0;
    o_reads   = 0;
    o_writes  = 0;
    o_error   = 1'b0;
    in_xfer   = 1'b0;
    wait_left = 0;
    forever begin
      // bus outputs are settled 1 ns after the edge
      @(posedge clk);
      #1;
      if (rst) begin
        o_ready = 1'b0;
        in_xfer = 1'b0;
      end else if (o_ready) begin
        // handshake took place at the edge just passed
        o_ready = 1'b0;
        in_xfer = 1'b0;
        if (held_op == BUS_WRITE) begin
          mem[held_addr] = held_wdata;
          o_writes++;
        end else begin
          o_reads++;
        end
      end else if (i_valid) begin
        if (i_size != BUS_SIZE_D) flag_error("burst size is not doubleword");
        if (i_blks != BUS_BLKS_LINE) flag_error("block count is not one line");
        if (i_addr[OFFSET_W-1:0] != '0) flag_error("address is not line aligned");
        if (!in_xfer) begin
          // new burst, pick its stall length
          in_xfer    = 1'b1;
          held_op    = i_op;
          held_addr  = i_addr;
          held_wdata = i_wdata;
          wait_left  = int'($urandom % 4);
        end else if (i_op != held_op || i_addr != held_addr || i_wdata != held_wdata) begin
          flag_error("bus outputs changed while stalled");
        end
        if (wait_left == 0) begin
          o_ready = 1'b1;
          o_rdata = fetch_line(held_addr);
        end else begin
          wait_left--;
        end
      end else if (in_xfer) begin
        flag_error("valid dropped before ready");
      end
    end
  end

endmodule

// File: test/tb_cache_top.sv
`timescale 1ns/1ps

module tb_cache_top;
  import cache_pkg::*;
  import bus_pkg::*;

  localparam int N_ENTRIES       = 17;
  localparam int HIT_CYCLES      = 2;
  localparam int WATCHDOG_CYCLES = 200 * N_ENTRIES + 100;

  // one row of stimulus with its expected results
  typedef struct packed {
    logic  we;
    addr_t addr;
    word_t wdata;
    word_t exp_data;
    logic  exp_hit;
    int    exp_reads;
    int    exp_writes;
  } entry_t;

  logic      clk;
  logic      rst;
  logic      cpu_valid;
  logic      cpu_we;
  addr_t     cpu_addr;
  word_t     cpu_wdata;
  logic      cpu_ready;
  logic      resp_valid;
  word_t     cpu_rdata;
  logic      bus_valid;
  bus_op_t   bus_op;
  bus_addr_t bus_addr;
  line_t     bus_wdata;
  logic [1:0] bus_size;
  logic [7:0] bus_blks;
  logic      bus_ready;
  line_t     bus_rdata;
  int        bus_reads;
  int        bus_writes;
  logic      bus_error;

  entry_t    stim [N_ENTRIES];
  int        n_built;
  // flat view of memory as the core sees it
  word_t     ref_mem [addr_t];
  // shadow of the cache state, for hit and transfer prediction
  tag_t      sh_tag [NUM_LINES];
  logic      sh_valid [NUM_LINES];
  logic      sh_dirty [NUM_LINES];
  int        ref_reads;
  int        ref_writes;

  cache_top dut_i (
    .clk, .rst,
    .i_cpu_valid(cpu_valid), .i_cpu_we(cpu_we), .i_cpu_addr(cpu_addr),
    .i_cpu_wdata(cpu_wdata), .o_cpu_ready(cpu_ready),
    .o_cpu_resp_valid(resp_valid), .o_cpu_rdata(cpu_rdata),
    .o_bus_valid(bus_valid), .o_bus_op(bus_op), .o_bus_addr(bus_addr),
    .o_bus_wdata(bus_wdata), .o_bus_size(bus_size), .o_bus_blks(bus_blks),
    .i_bus_ready(bus_ready), .i_bus_rdata(bus_rdata)
  );

  bus_mem_model mem_i (
    .clk, .rst,
    .i_valid(bus_valid), .i_op(bus_op), .i_addr(bus_addr), .i_wdata(bus_wdata),
    .i_size(bus_size), .i_blks(bus_blks), .o_ready(bus_ready), .o_rdata(bus_rdata),
    .o_reads(bus_reads), .o_writes(bus_writes), .o_error(bus_error)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic halt_run();
    $display("Done: errors found");
    $fatal(1, "stopped at first failure");
  endtask

  // memory content before any write, per 8-byte word
  function automatic word_t initial_word(addr_t a);
    return {a ^ 32'h5a5a_c3c3, a ^ 32'h0f0f_1234};
  endfunction

  function automatic word_t ref_read(addr_t a);
    addr_t wa;
    wa = {a[31:3], 3'b000};
    if (ref_mem.exists(wa)) begin
      return ref_mem[wa];
    end
    return initial_word(wa);
  endfunction

  // adds a row and moves the reference model past it
  task automatic push_entry(input logic we, input addr_t addr, input word_t wdata);
    index_t idx;
    tag_t   tg;
    entry_t e;
    idx       = addr[OFFSET_W +: INDEX_W];
    tg        = addr[31 -: TAG_W];
    e.we      = we;
    e.addr    = addr;
    e.wdata   = wdata;
    e.exp_hit = sh_valid[idx] && (sh_tag[idx] == tg);
    if (!e.exp_hit) begin
      // dirty victim goes out before the refill
      if (sh_valid[idx] && sh_dirty[idx]) ref_writes++;
      ref_reads++;
      sh_valid[idx] = 1'b1;
      sh_tag[idx]   = tg;
      sh_dirty[idx] = 1'b0;
    end
    if (we) begin
      ref_mem[{addr[31:3], 3'b000}] = wdata;
      sh_dirty[idx] = 1'b1;
    end
    e.exp_data    = ref_read(addr);
    e.exp_reads   = ref_reads;
    e.exp_writes  = ref_writes;
    stim[n_built] = e;
    n_built++;
  endtask

  task automatic expect_word(input string name, input word_t act, input word_t exp);
    if (act !== exp) begin
      $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
      halt_run();
    end
  endtask

  task automatic check_latency(input string name, input int act, input int exp);
    if (act != exp) begin
      $display("mismatch at %0t: %s expected %0d actual %0d", $time, name, exp, act);
      halt_run();
    end
  endtask

  task automatic compare_count(input string name, input int act, input int exp);
    if (act != exp) begin
      $display("mismatch at %0t: %s expected %0d actual %0d", $time, name, exp, act);
      halt_run();
    end
  endtask

  task automatic verify_flag(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("mismatch at %0t: %s expected %b actual %b", $time, name, exp, act);
      halt_run();
    end
  endtask

  // one core request, returns data and cycles from acceptance
  task automatic run_request(input entry_t e, output word_t rdata, output int lat);
    while (!cpu_ready) begin
      @(posedge clk);
      #1;
    end
    cpu_valid = 1'b1;
    cpu_we    = e.we;
    cpu_addr  = e.addr;
    cpu_wdata = e.wdata;
    lat       = 0;
    do begin
      @(posedge clk);
      #1;
      cpu_valid = 1'b0;
      lat++;
    end while (!resp_valid);
    rdata = cpu_rdata;
  endtask

  initial begin
    entry_t e;
    word_t  rdata;
    int     lat;
    rst        = 1'b1;
    cpu_valid  = 1'b0;
    cpu_we     = 1'b0;
    cpu_addr   = '0;
    cpu_wdata  = '0;
    n_built    = 0;
    ref_reads  = 0;
    ref_writes = 0;
    for (int i = 0; i < NUM_LINES; i++) begin
      sh_valid[i] = 1'b0;
      sh_dirty[i] = 1'b0;
      sh_tag[i]   = '0;
    end
    // miss, hits, write hit, readback of both words
    push_entry(1'b0, 32'h0000_0100, 64'h0);
    push_entry(1'b0, 32'h0000_0118, 64'h0);
    push_entry(1'b1, 32'h0000_0108, 64'h1122_3344_5566_7788);
    push_entry(1'b0, 32'h0000_0108, 64'h0);
    push_entry(1'b0, 32'h0000_0110, 64'h0);
    // index 1, write line A then conflict line B then A again
    push_entry(1'b1, 32'h0000_1048, 64'hdead_beef_0bad_f00d);
    push_entry(1'b0, 32'h0000_2040, 64'h0);
    push_entry(1'b0, 32'h0000_1048, 64'h0);
    push_entry(1'b0, 32'h0000_1050, 64'h0);
    // index 4 evicted while dirty
    push_entry(1'b1, 32'h0000_0100, 64'h0123_4567_89ab_cdef);
    push_entry(1'b0, 32'h0001_0100, 64'h0);
    push_entry(1'b0, 32'h0000_0108, 64'h0);
    // index 15, top of the address space
    push_entry(1'b1, 32'h0000_03f8, 64'ha5a5_5a5a_ffff_0000);
    push_entry(1'b0, 32'h0000_03f8, 64'h0);
    push_entry(1'b1, 32'hffff_fff8, 64'hcafe_f00d_1357_2468);
    push_entry(1'b0, 32'hffff_ffc0, 64'h0);
    push_entry(1'b0, 32'h0000_03f8, 64'h0);
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    // quiet and ready before the first request
    repeat (4) begin
      @(posedge clk);
      #1;
      verify_flag("o_bus_valid", bus_valid, 1'b0);
      verify_flag("o_cpu_resp_valid", resp_valid, 1'b0);
      verify_flag("o_cpu_ready", cpu_ready, 1'b1);
    end
    for (int i = 0; i < N_ENTRIES; i++) begin
      e = stim[i];
      run_request(e, rdata, lat);
      expect_word("o_cpu_rdata", rdata, e.exp_data);
      if (e.exp_hit) check_latency("hit latency", lat, HIT_CYCLES);
      verify_flag("hit", lat == HIT_CYCLES, e.exp_hit);
      compare_count("bus reads", bus_reads, e.exp_reads);
      compare_count("bus writes", bus_writes, e.exp_writes);
    end
    $display("Done: no errors");
    $finish;
  end

  initial begin
    wait (bus_error === 1'b1);
    $display("bus model reported a protocol violation");
    halt_run();
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    halt_run();
  end

endmodule

// File: flist.f
common/cache_pkg.sv
common/bus_pkg.sv
cache/cache_store.sv
cache/cache_ctrl.sv
cache/cache_line_bridge.sv
rtl/cache_top.sv
test/bus_mem_model.sv
test/tb_cache_top.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the cache testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

if ! verilator --binary --timing --assert --top-module tb_cache_top \
    -f flist.f --Mdir "$BUILD" -o sim_cache; then
  echo "build failed"
  exit 1
fi

"./$BUILD/sim_cache" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Done: errors found" "$LOG"; then
  echo "simulation FAILED"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
echo "simulation passed"
exit 0
